/* include/vmul_macros.svh */
//////////////////////////////////////////////////////////////////////
// widths, lane counts and instruction encodings for the vector
// multiply unit
//////////////////////////////////////////////////////////////////////

`ifndef VMUL_MACROS_SVH
`define VMUL_MACROS_SVH

// datapath sizes
`define VMUL_VLEN      128
`define VMUL_XLEN      32
`define VMUL_ROB_W     4
`define VMUL_FUNCT6_W  6
`define VMUL_FUNCT3_W  3
`define VMUL_BYTES     16             // byte lanes per vector register
`define VMUL_PARTS     64             // 4x4 byte products per 32-bit group

// funct6 codes
`define VMUL_F6_VMUL     6'b100101
`define VMUL_F6_VMULH    6'b100111
`define VMUL_F6_VMULHU   6'b100100
`define VMUL_F6_VMULHSU  6'b100110
`define VMUL_F6_VSMUL    6'b100111    // same code, OPIVV/OPIVX space

// funct3 operand categories
`define VMUL_F3_OPIVV  3'b000
`define VMUL_F3_OPMVV  3'b010
`define VMUL_F3_OPIVX  3'b100
`define VMUL_F3_OPMVX  3'b110

`endif

/* design/vmul_pkg.sv */
//////////////////////////////////////////////////////////////////////
// enumerated types shared by the vector multiply unit: element
// width, fixed-point rounding mode, operand category
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vmul_macros.svh"

package vmul_pkg;

  // selected element width, unused codes fall back to 8 bits
  typedef enum logic [2:0] {
    EEW8  = 3'd0,
    EEW16 = 3'd1,
    EEW32 = 3'd2
  } eew_e;

  // vxrm fixed-point rounding modes
  typedef enum logic [1:0] {
    RNU = 2'd0,                       // round to nearest, ties up
    RNE = 2'd1,                       // round to nearest, ties even
    RDN = 2'd2,                       // truncate
    ROD = 2'd3                        // jam to odd
  } vxrm_e;

  // funct3 categories handled here, everything else is ignored
  typedef enum logic [`VMUL_FUNCT3_W-1:0] {
    CAT_OPIVV = `VMUL_F3_OPIVV,
    CAT_OPMVV = `VMUL_F3_OPMVV,
    CAT_OPIVX = `VMUL_F3_OPIVX,
    CAT_OPMVX = `VMUL_F3_OPMVX
  } opcat_e;

endpackage

`default_nettype wire

/* design/vmul_decode.sv */
//////////////////////////////////////////////////////////////////////
// micro-op decode: operand signedness, high/low select, vsmul flag,
// scalar replication and per-byte sign flags
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vmul_macros.svh"

module vmul_decode
  import vmul_pkg::*;
(
  input  logic                      valid,
  input  logic [`VMUL_FUNCT6_W-1:0] funct6,
  input  logic [`VMUL_FUNCT3_W-1:0] funct3,
  input  eew_e                      eew,
  input  logic [`VMUL_VLEN-1:0]     vs2,
  input  logic [`VMUL_VLEN-1:0]     vs1,
  input  logic [`VMUL_XLEN-1:0]     rs1,
  output logic [`VMUL_VLEN-1:0]     src2,
  output logic [`VMUL_VLEN-1:0]     src1,
  output logic [`VMUL_BYTES-1:0]    src2_signed,
  output logic [`VMUL_BYTES-1:0]    src1_signed,
  output logic                      prod_signed,
  output logic                      keep_low,
  output logic                      is_vsmul
);

  opcat_e                 cat;
  logic                   known;      // funct3 belongs to this unit
  logic                   use_rs1;
  logic                   sgn2;
  logic                   sgn1;
  logic                   low;
  logic                   smul;
  logic                   en;
  logic [`VMUL_VLEN-1:0]  scalar_rep; // rs1 copied into every element
  logic [`VMUL_BYTES-1:0] msb_byte;   // top byte of each element

  assign cat = opcat_e'(funct3);

  //////////////////////////////////////////////////////////////////////
  // operation decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    known   = 1'b1;
    use_rs1 = 1'b0;
    sgn2    = 1'b1;
    sgn1    = 1'b1;
    low     = 1'b0;
    smul    = 1'b0;
    case (cat)
      CAT_OPMVV, CAT_OPMVX: begin
        use_rs1 = (cat == CAT_OPMVX);
        case (funct6)
          `VMUL_F6_VMULH:   low = 1'b0;       // signed x signed, high half
          `VMUL_F6_VMULHU: begin
            sgn2 = 1'b0;
            sgn1 = 1'b0;
          end
          `VMUL_F6_VMULHSU: sgn1 = 1'b0;      // vs2 signed, vs1/rs1 unsigned
          default:          low  = 1'b1;      // vmul and unknown codes
        endcase
      end
      CAT_OPIVV, CAT_OPIVX: begin
        // any funct6 in this space runs as vsmul
        use_rs1 = (cat == CAT_OPIVX);
        smul    = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // scalar replication and sign byte positions per element width
  always_comb begin
    case (eew)
      EEW16: begin
        scalar_rep = {8{rs1[15:0]}};
        msb_byte   = {8{2'b10}};
      end
      EEW32: begin
        scalar_rep = {4{rs1}};
        msb_byte   = {4{4'b1000}};
      end
      default: begin
        scalar_rep = {16{rs1[7:0]}};
        msb_byte   = '1;
      end
    endcase
  end

  assign en          = valid & known;
  assign src2        = en ? vs2 : '0;
  assign src1        = en ? (use_rs1 ? scalar_rep : vs1) : '0;
  assign src2_signed = (en & sgn2) ? msb_byte : '0;
  assign src1_signed = (en & sgn1) ? msb_byte : '0;
  assign prod_signed = en & (sgn2 | sgn1);
  assign keep_low    = en & low;
  assign is_vsmul    = en & smul;

endmodule

`default_nettype wire

/* design/vmul_mul8_array.sv */
//////////////////////////////////////////////////////////////////////
// 64 signed/unsigned 8x8 byte multipliers and the pipeline register
// for the products and the micro-op control fields
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vmul_macros.svh"

module vmul_mul8_array
  import vmul_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    valid,
  input  logic [`VMUL_VLEN-1:0]   src2,
  input  logic [`VMUL_VLEN-1:0]   src1,
  input  logic [`VMUL_BYTES-1:0]  src2_signed,
  input  logic [`VMUL_BYTES-1:0]  src1_signed,
  input  logic                    prod_signed,
  input  logic                    keep_low,
  input  logic                    is_vsmul,
  input  vxrm_e                   vxrm,
  input  eew_e                    eew,
  input  logic [`VMUL_ROB_W-1:0]  rob_entry,
  output logic [15:0]             part [`VMUL_PARTS],
  output logic                    valid_q,
  output logic                    prod_signed_q,
  output logic                    src1_signed_q,
  output logic                    keep_low_q,
  output logic                    is_vsmul_q,
  output vxrm_e                   vxrm_q,
  output eew_e                    eew_q,
  output logic [`VMUL_ROB_W-1:0]  rob_entry_q
);

  logic [15:0] prod [`VMUL_PARTS];

  //////////////////////////////////////////////////////////////////////
  // byte products, one 4x4 tile per 32-bit group
  // part index is grp*16 + row*4 + col, col = src2 byte, row = src1 byte
  //////////////////////////////////////////////////////////////////////
  for (genvar g = 0; g < `VMUL_BYTES / 4; g++) begin : g_grp
    for (genvar x = 0; x < 4; x++) begin : g_col
      for (genvar y = 0; y < 4; y++) begin : g_row
        localparam int IA = g * 4 + x;
        localparam int IB = g * 4 + y;

        logic signed [8:0]  op_a;
        logic signed [8:0]  op_b;
        logic signed [17:0] full;

        assign op_a = {src2_signed[IA] & src2[IA*8+7], src2[IA*8 +: 8]};  // 9-bit extend
        assign op_b = {src1_signed[IB] & src1[IB*8+7], src1[IB*8 +: 8]};
        assign full = op_a * op_b;
        assign prod[g*16 + y*4 + x] = full[15:0];  // 16 bits hold every sign mix
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      part          <= '{default: 16'h0};
      valid_q       <= 1'b0;
      prod_signed_q <= 1'b0;
      src1_signed_q <= 1'b0;
      keep_low_q    <= 1'b0;
      is_vsmul_q    <= 1'b0;
      vxrm_q        <= RNU;
      eew_q         <= EEW8;
      rob_entry_q   <= '0;
    end else begin
      part          <= prod;
      valid_q       <= valid;
      prod_signed_q <= prod_signed;
      src1_signed_q <= |src1_signed;  // vs1/rs1 side signedness
      keep_low_q    <= keep_low;
      is_vsmul_q    <= is_vsmul;
      vxrm_q        <= vxrm;
      eew_q         <= eew;
      rob_entry_q   <= rob_entry;
    end
  end

endmodule

`default_nettype wire

/* design/vmul_result.sv */
//////////////////////////////////////////////////////////////////////
// result stage: element products from byte products, high/low
// select, vsmul rounding and saturation, vxsat
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vmul_macros.svh"

module vmul_result
  import vmul_pkg::*;
(
  input  logic [15:0]            part [`VMUL_PARTS],
  input  logic                   prod_signed,
  input  logic                   src1_signed,
  input  logic                   keep_low,
  input  logic                   is_vsmul,
  input  vxrm_e                  vxrm,
  input  eew_e                   eew,
  output logic [`VMUL_VLEN-1:0]  data,
  output logic                   vxsat
);

  logic [`VMUL_VLEN:0] res8;    // {vxsat, data} per element width
  logic [`VMUL_VLEN:0] res16;
  logic [`VMUL_VLEN:0] res32;

  // full product of element e, nb bytes wide
  // a term is sign extended when it holds a signed element msb byte;
  // when prod_signed is set the vs2 side is always signed
  function automatic logic [63:0] elem_full(input int nb, input int e);
    logic [63:0] acc;
    logic        ext;
    int          grp;
    int          lo;
    int          idx;
    acc = '0;
    grp = (e * nb) / 4;
    lo  = (e * nb) % 4;
    for (int xb = 0; xb < nb; xb++) begin
      for (int yb = 0; yb < nb; yb++) begin
        idx = grp * 16 + (lo + yb) * 4 + lo + xb;
        ext = ((xb == nb - 1) && prod_signed) || ((yb == nb - 1) && src1_signed);
        acc = acc + ({{48{ext & part[idx][15]}}, part[idx]} << (8 * (xb + yb)));
      end
    end
    return acc;
  endfunction

  // vsmul of one element, returns {sat, value}
  function automatic logic [32:0] vsmul_elem(input logic [63:0] full, input vxrm_e rm,
                                             input int sew);
    logic [63:0] kept;
    logic        rbit;
    logic        sticky;
    logic        incr;
    logic        sat;
    kept   = full >> (sew - 1);
    rbit   = full[sew - 2];                             // first dropped bit
    sticky = |(full & ((64'd1 << (sew - 2)) - 64'd1));  // rest of the dropped bits
    case (rm)
      RNU:     incr = rbit;
      RNE:     incr = rbit & (sticky | kept[0]);
      RDN:     incr = 1'b0;
      default: incr = ~kept[0] & (rbit | sticky);       // ROD
    endcase
    sat  = (full[2*sew-1 -: 2] == 2'b01);  // only min x min lands here
    kept = sat ? (64'd1 << (sew - 1)) - 64'd1 : kept + 64'(incr);
    return {sat, kept[31:0]};
  endfunction

  // whole register for one element width
  function automatic logic [`VMUL_VLEN:0] lane_result(input int nb);
    logic [`VMUL_VLEN-1:0] acc;
    logic                  sat;
    logic [63:0]           full;
    logic [32:0]           vs;
    logic [31:0]           pick;
    logic [31:0]           mask;
    int                    sew;
    acc  = '0;
    sat  = 1'b0;
    sew  = 8 * nb;
    mask = 32'((64'd1 << sew) - 64'd1);
    for (int e = 0; e < `VMUL_BYTES / nb; e++) begin
      full = elem_full(nb, e);
      vs   = vsmul_elem(full, vxrm, sew);
      if (is_vsmul) begin
        pick = vs[31:0];
      end else if (keep_low) begin
        pick = full[31:0];
      end else begin
        pick = 32'(full >> sew);   // high half
      end
      acc = acc | (`VMUL_VLEN'(pick & mask) << (e * sew));
      sat = sat | (vs[32] & is_vsmul);
    end
    return {sat, acc};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // width select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    res8  = lane_result(1);
    res16 = lane_result(2);
    res32 = lane_result(4);
    case (eew)
      EEW16:   {vxsat, data} = res16;
      EEW32:   {vxsat, data} = res32;
      default: {vxsat, data} = res8;
    endcase
  end

endmodule

`default_nettype wire

/* design/vmul_unit.sv */
//////////////////////////////////////////////////////////////////////
// vector multiply unit top: decode, byte multiplier array with its
// pipeline register, result stage
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vmul_macros.svh"

module vmul_unit
  import vmul_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  input  logic [`VMUL_FUNCT6_W-1:0] in_funct6,
  input  logic [`VMUL_FUNCT3_W-1:0] in_funct3,
  input  vxrm_e                     in_vxrm,
  input  eew_e                      in_eew,
  input  logic [`VMUL_VLEN-1:0]     in_vs2,
  input  logic [`VMUL_VLEN-1:0]     in_vs1,
  input  logic [`VMUL_XLEN-1:0]     in_rs1,
  input  logic [`VMUL_ROB_W-1:0]    in_rob_entry,
  output logic                      out_valid,
  output logic [`VMUL_ROB_W-1:0]    out_rob_entry,
  output logic [`VMUL_VLEN-1:0]     out_data,
  output logic                      out_vxsat
);

  logic [`VMUL_VLEN-1:0]  src2;
  logic [`VMUL_VLEN-1:0]  src1;
  logic [`VMUL_BYTES-1:0] src2_signed;
  logic [`VMUL_BYTES-1:0] src1_signed;
  logic                   prod_signed;
  logic                   keep_low;
  logic                   is_vsmul;
  logic [15:0]            part [`VMUL_PARTS];
  logic                   prod_signed_q;
  logic                   src1_signed_q;
  logic                   keep_low_q;
  logic                   is_vsmul_q;
  vxrm_e                  vxrm_q;
  eew_e                   eew_q;

  vmul_decode u_decode (
    .valid       (in_valid),
    .funct6      (in_funct6),
    .funct3      (in_funct3),
    .eew         (in_eew),
    .vs2         (in_vs2),
    .vs1         (in_vs1),
    .rs1         (in_rs1),
    .src2        (src2),
    .src1        (src1),
    .src2_signed (src2_signed),
    .src1_signed (src1_signed),
    .prod_signed (prod_signed),
    .keep_low    (keep_low),
    .is_vsmul    (is_vsmul)
  );

  vmul_mul8_array u_array (
    .clk           (clk),
    .reset         (reset),
    .valid         (in_valid),
    .src2          (src2),
    .src1          (src1),
    .src2_signed   (src2_signed),
    .src1_signed   (src1_signed),
    .prod_signed   (prod_signed),
    .keep_low      (keep_low),
    .is_vsmul      (is_vsmul),
    .vxrm          (in_vxrm),
    .eew           (in_eew),
    .rob_entry     (in_rob_entry),
    .part          (part),
    .valid_q       (out_valid),       // one cycle after acceptance
    .prod_signed_q (prod_signed_q),
    .src1_signed_q (src1_signed_q),
    .keep_low_q    (keep_low_q),
    .is_vsmul_q    (is_vsmul_q),
    .vxrm_q        (vxrm_q),
    .eew_q         (eew_q),
    .rob_entry_q   (out_rob_entry)
  );

  vmul_result u_result (
    .part        (part),
    .prod_signed (prod_signed_q),
    .src1_signed (src1_signed_q),
    .keep_low    (keep_low_q),
    .is_vsmul    (is_vsmul_q),
    .vxrm        (vxrm_q),
    .eew         (eew_q),
    .data        (out_data),
    .vxsat       (out_vxsat)
  );

endmodule

`default_nettype wire

/* test/vmul_tb.sv */
//////////////////////////////////////////////////////////////////////
// vector multiply unit testbench with clock and reset, LFSR
// stimulus, per-element reference model, output checks and watchdog
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "vmul_macros.svh"

module vmul_tb
  import vmul_pkg::*;
();

  localparam int N_STREAM = 40;
  localparam int N_VMUL   = 12;
  localparam int N_HIGH   = 18;
  localparam int N_ROUND  = 24;
  localparam int N_SAT    = 6;
  localparam int N_UNK    = 6;
  localparam int N_UOPS   = N_STREAM + N_VMUL + N_HIGH + N_ROUND + N_SAT + N_UNK;

  logic                      clk;
  logic                      reset;
  logic                      in_valid;
  logic [`VMUL_FUNCT6_W-1:0] in_funct6;
  logic [`VMUL_FUNCT3_W-1:0] in_funct3;
  vxrm_e                     in_vxrm;
  eew_e                      in_eew;
  logic [`VMUL_VLEN-1:0]     in_vs2;
  logic [`VMUL_VLEN-1:0]     in_vs1;
  logic [`VMUL_XLEN-1:0]     in_rs1;
  logic [`VMUL_ROB_W-1:0]    in_rob_entry;
  logic                      out_valid;
  logic [`VMUL_ROB_W-1:0]    out_rob_entry;
  logic [`VMUL_VLEN-1:0]     out_data;
  logic                      out_vxsat;

  string                     exp_name [$];   // one entry per accepted micro-op
  logic [`VMUL_VLEN-1:0]     exp_data [$];
  logic                      exp_sat [$];
  logic [`VMUL_ROB_W-1:0]    exp_rob [$];
  logic                      exp_valid;      // op accepted at the previous edge
  logic [31:0]               lfsr_state;
  logic [`VMUL_ROB_W-1:0]    rob_cnt;
  int                        errors;
  int                        checks;

  vmul_unit dut (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_funct6     (in_funct6),
    .in_funct3     (in_funct3),
    .in_vxrm       (in_vxrm),
    .in_eew        (in_eew),
    .in_vs2        (in_vs2),
    .in_vs1        (in_vs1),
    .in_rs1        (in_rs1),
    .in_rob_entry  (in_rob_entry),
    .out_valid     (out_valid),
    .out_rob_entry (out_rob_entry),
    .out_data      (out_data),
    .out_vxsat     (out_vxsat)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // random bits and reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic int sew_of(input logic [2:0] ew);
    return (ew == 3'd1) ? 16 : (ew == 3'd2) ? 32 : 8;  // reserved codes act as 8
  endfunction

  // returns {vxsat, data} for one micro-op
  function automatic logic [128:0] expected_result(input logic [5:0] f6, input logic [2:0] f3,
                                                   input logic [1:0] rm, input logic [2:0] ew,
                                                   input logic [127:0] vs2,
                                                   input logic [127:0] vs1,
                                                   input logic [31:0] rs1);
    logic [127:0] res;
    logic [127:0] mask;
    logic [127:0] a;
    logic [127:0] b;
    logic [127:0] p;
    logic [127:0] sh;
    logic         sat;
    logic         sa;
    logic         sb;
    logic         high;
    logic         smul;
    logic         rbit;
    logic         sticky;
    logic         incr;
    int           sew;
    sew  = sew_of(ew);
    mask = (128'd1 << sew) - 128'd1;
    smul = (f3 == `VMUL_F3_OPIVV) || (f3 == `VMUL_F3_OPIVX);
    sa   = 1'b1;
    sb   = 1'b1;
    high = 1'b0;
    if (!smul) begin
      case (f6)
        `VMUL_F6_VMULH:   high = 1'b1;
        `VMUL_F6_VMULHU:  {high, sa, sb} = 3'b100;
        `VMUL_F6_VMULHSU: {high, sb} = 2'b10;
        default:          high = 1'b0;             // plain vmul
      endcase
    end
    res = '0;
    sat = 1'b0;
    for (int e = 0; e < 128 / sew; e++) begin
      a = (vs2 >> (e * sew)) & mask;
      if ((f3 == `VMUL_F3_OPMVX) || (f3 == `VMUL_F3_OPIVX)) b = {96'd0, rs1} & mask;
      else b = (vs1 >> (e * sew)) & mask;
      if (smul && (a == (128'd1 << (sew - 1))) && (b == (128'd1 << (sew - 1)))) begin
        sat = 1'b1;
        p   = mask >> 1;                           // largest positive element
      end else begin
        if (sa && a[sew-1]) a = a | ~mask;
        if (sb && b[sew-1]) b = b | ~mask;
        p = a * b;
        if (smul) begin
          sh     = p >> (sew - 1);
          rbit   = p[sew-2];
          sticky = |(p & ((128'd1 << (sew - 2)) - 128'd1));
          case (rm)
            2'd0:    incr = rbit;
            2'd1:    incr = rbit & (sticky | sh[0]);
            2'd2:    incr = 1'b0;
            default: incr = ~sh[0] & (rbit | sticky);
          endcase
          p = sh + {127'd0, incr};
        end else if (high) begin
          p = p >> sew;
        end
      end
      res = res | ((p & mask) << (e * sew));
    end
    return {sat, res};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drivers on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic send_uop(input string name, input logic [5:0] f6, input logic [2:0] f3,
                          input logic [1:0] rm, input logic [2:0] ew, input logic [127:0] a,
                          input logic [127:0] b, input logic [31:0] s);
    logic [128:0] exp;
    @(negedge clk);
    in_valid     = 1'b1;
    in_funct6    = f6;
    in_funct3    = f3;
    in_vxrm      = vxrm_e'(rm);
    in_eew       = eew_e'(ew);
    in_vs2       = a;
    in_vs1       = b;
    in_rs1       = s;
    in_rob_entry = rob_cnt;
    exp          = expected_result(f6, f3, rm, ew, a, b, s);
    exp_name.push_back(name);
    exp_data.push_back(exp[127:0]);
    exp_sat.push_back(exp[128]);
    exp_rob.push_back(rob_cnt);
    rob_cnt = rob_cnt + 4'd1;
  endtask

  task automatic send_random(input string name, input logic [5:0] f6, input logic [2:0] f3,
                             input logic [1:0] rm, input logic [2:0] ew);
    logic [127:0] a;
    logic [127:0] b;
    logic [31:0]  s;
    a = rand_bits(128);
    b = rand_bits(128);
    s = 32'(rand_bits(32));
    send_uop(name, f6, f3, rm, ew, a, b, s);
  endtask

  // vsmul with one element where both operands are the minimum
  task automatic send_saturate(input logic [2:0] ew, input logic scalar);
    logic [127:0] a;
    logic [127:0] b;
    logic [127:0] field;
    logic [127:0] minv;
    logic [31:0]  s;
    int           sew;
    int           k;
    sew   = sew_of(ew);
    k     = int'(rand_bits(4)) % (128 / sew);
    field = ((128'd1 << sew) - 128'd1) << (k * sew);
    minv  = 128'd1 << (k * sew + sew - 1);
    a     = (rand_bits(128) & ~field) | minv;
    b     = (rand_bits(128) & ~field) | minv;
    s     = scalar ? (32'd1 << (sew - 1)) : 32'(rand_bits(32));
    send_uop("vsmul_sat", `VMUL_F6_VSMUL, scalar ? `VMUL_F3_OPIVX : `VMUL_F3_OPIVV,
             2'(rand_bits(2)), ew, a, b, s);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // output checks at each rising edge
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin : check_outputs
    string                  nm;
    logic [`VMUL_VLEN-1:0]  d;
    logic                   s;
    logic [`VMUL_ROB_W-1:0] r;
    if (!reset) begin
      if (exp_valid) begin
        nm = exp_name.pop_front();
        d  = exp_data.pop_front();
        s  = exp_sat.pop_front();
        r  = exp_rob.pop_front();
        checks = checks + 1;
        assert (out_valid) else begin
          errors = errors + 1;
          $display("Error: %s out_valid expected 1 actual %0b", nm, out_valid);
        end
        assert (out_rob_entry == r) else begin
          errors = errors + 1;
          $display("Error: %s rob_entry expected %h actual %h", nm, r, out_rob_entry);
        end
        assert (out_data == d) else begin
          errors = errors + 1;
          $display("Error: %s data expected %h actual %h", nm, d, out_data);
        end
        assert (out_vxsat == s) else begin
          errors = errors + 1;
          $display("Error: %s vxsat expected %0b actual %0b", nm, s, out_vxsat);
        end
      end else begin
        assert (!out_valid) else begin
          errors = errors + 1;
          $display("out_valid went high with no micro-op accepted one cycle before");
        end
      end
    end
    exp_valid = in_valid && !reset;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin : run_tests
    logic [5:0] high_f6 [3];
    string      high_nm [3];
    logic [5:0] f6;
    high_f6 = '{`VMUL_F6_VMULH, `VMUL_F6_VMULHU, `VMUL_F6_VMULHSU};
    high_nm = '{"vmulh_vx", "vmulhu_vx", "vmulhsu_vx"};
    reset        = 1'b1;
    in_valid     = 1'b1;                       // offered during reset and dropped
    in_funct6    = '0;
    in_funct3    = '0;
    in_vxrm      = RNU;
    in_eew       = EEW8;
    in_vs2       = '0;
    in_vs1       = '0;
    in_rs1       = '0;
    in_rob_entry = '0;
    exp_valid    = 1'b0;
    lfsr_state   = 32'hd05f;
    rob_cnt      = '0;
    errors       = 0;
    checks       = 0;
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      assert (out_valid == 1'b0) else begin
        errors = errors + 1;
        $display("Error: reset out_valid expected 0 actual %0b", out_valid);
      end
    end
    reset    = 1'b0;
    in_valid = 1'b0;

    // mixed stream with a gap after every fourth op
    for (int i = 0; i < N_STREAM; i++) begin
      case (2'(rand_bits(2)))
        2'd0:    f6 = `VMUL_F6_VMUL;
        2'd1:    f6 = `VMUL_F6_VMULH;
        2'd2:    f6 = `VMUL_F6_VMULHU;
        default: f6 = `VMUL_F6_VMULHSU;
      endcase
      send_random("stream", f6, rand_bits(1) != 128'd0 ? `VMUL_F3_OPMVX : `VMUL_F3_OPMVV,
                  2'd0, 3'(rand_bits(2)));
      if (i % 4 == 3) idle_cycle();
    end

    for (int w = 0; w < 3; w++)
      repeat (N_VMUL / 3) send_random("vmul_vv", `VMUL_F6_VMUL, `VMUL_F3_OPMVV, 2'd0, 3'(w));

    for (int f = 0; f < 3; f++)
      for (int w = 0; w < 3; w++)
        repeat (2) send_random(high_nm[f], high_f6[f], `VMUL_F3_OPMVX, 2'd0, 3'(w));

    for (int m = 0; m < 4; m++) begin
      for (int w = 0; w < 3; w++) begin
        send_random("vsmul_round", `VMUL_F6_VSMUL, `VMUL_F3_OPIVV, 2'(m), 3'(w));
        send_random("vsmul_round", `VMUL_F6_VSMUL, `VMUL_F3_OPIVX, 2'(m), 3'(w));
      end
    end

    for (int w = 0; w < 3; w++) begin
      send_saturate(3'(w), 1'b0);
      send_saturate(3'(w), 1'b1);
    end

    // codes outside the supported funct6 set
    for (int w = 0; w < 3; w++) begin
      send_random("unknown_mvv", 6'b000000, `VMUL_F3_OPMVV, 2'd0, 3'(w));
      send_random("unknown_ivv", 6'b000011, `VMUL_F3_OPIVV, 2'(rand_bits(2)), 3'(w));
    end

    idle_cycle();
    while (exp_data.size() != 0) @(posedge clk);
    repeat (2) @(negedge clk);                 // no late or repeated results
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    #((N_UOPS + 20) * 20);
    $display("timeout after %0d time units, %0d results still pending",
             (N_UOPS + 20) * 20, exp_data.size());
    $display("checks=%0d errors=%0d", checks, errors);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
design/vmul_pkg.sv
design/vmul_decode.sv
design/vmul_mul8_array.sv
design/vmul_result.sv
design/vmul_unit.sv
test/vmul_tb.sv

/* Makefile */
# Verilator build and run of the vector multiply unit testbench

VERILATOR ?= verilator
TOP       ?= vmul_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
